// File: sim.f
src/lsu_pkg.sv
src/dmem_if.sv
src/lsu_issue.sv
src/dmem_ram.sv
src/load_align.sv
src/lsu_top.sv
sim/lsu_assert.sv
sim/tb_lsu.sv

// File: sim/tb_lsu.sv
`timescale 1ns/1ps
`default_nettype none

module tb_lsu import lsu_pkg::*; ();

  localparam int CLK_PERIOD = 100;
  localparam int RST_CYCLES = 16;
  localparam int N_ACC      = 100;   // Accesses over all tests, rounded up

  logic             clk;
  logic             rstn;
  logic             ex_stall;
  logic             id_bubble;
  logic [ILEN-1:0]  id_instr;
  logic [EXC_W-1:0] id_exception;
  logic [XLEN-1:0]  op_a;
  logic [XLEN-1:0]  op_b;
  logic             lsu_stall;
  logic             lsu_bubble;
  logic [XLEN-1:0]  lsu_r;
  logic [EXC_W-1:0] lsu_exception;
  logic [7:0]       ref_mem [RAM_WORDS*LANES];  // Byte-wide reference model
  logic [31:0]      rng = 32'd73547;

  lsu_top i_lsu_top (.*);

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD/2) clk = ~clk;
  end

  //////////////////////////////////////////////////
  // Helpers

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Result: FAILED");
    $fatal(1);
  endtask

  task automatic check_data(input string name, input logic [XLEN-1:0] got, exp);
    if (got !== exp) report_failure($sformatf("error: %s got %h expected %h", name, got, exp));
  endtask

  task automatic check_exc(input string name, input logic [EXC_W-1:0] got, exp);
    if (got !== exp) report_failure($sformatf("error: %s got %h expected %h", name, got, exp));
  endtask

  function automatic logic [31:0] rand32();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  function automatic int nbytes(input logic [2:0] f3);
    case (f3)
      F3_B, F3_BU: return 1;
      F3_H, F3_HU: return 2;
      default:     return 4;
    endcase
  endfunction

  function automatic void ref_store(input logic [9:0] addr, input logic [2:0] f3,
                                    input logic [XLEN-1:0] data);
    for (int i = 0; i < nbytes(f3); i++) ref_mem[addr + i] = data[8*i +: 8];
  endfunction

  function automatic logic [XLEN-1:0] ref_load(input logic [9:0] addr, input logic [2:0] f3);
    logic [XLEN-1:0] raw;
    raw = '0;                                  // Unsigned forms stay zero filled
    for (int i = 0; i < nbytes(f3); i++) raw[8*i +: 8] = ref_mem[addr + i];
    if (f3 == F3_B) return {{(XLEN-8){raw[7]}}, raw[7:0]};
    if (f3 == F3_H) return {{(XLEN-16){raw[15]}}, raw[15:0]};
    return raw;
  endfunction

  // I-type load, S-type store
  function automatic logic [ILEN-1:0] enc_load(input logic [2:0] f3);
    return {12'h000, 5'd1, f3, 5'd2, OPC_LOAD, 2'b11};
  endfunction

  function automatic logic [ILEN-1:0] enc_store(input logic [2:0] f3, input logic [11:0] imm);
    return {imm[11:5], 5'd3, 5'd1, f3, imm[4:0], OPC_STORE, 2'b11};
  endfunction

  //////////////////////////////////////////////////
  // Access tasks

  // One instruction, waits for completion or a refusal
  task automatic run_instr(input logic [ILEN-1:0] instr, input logic [XLEN-1:0] a, b,
                           input logic [EXC_W-1:0] exc,
                           output logic [XLEN-1:0] r, output logic [EXC_W-1:0] e);
    int n;
    @(negedge clk);
    id_instr     = instr;
    op_a         = a;
    op_b         = b;
    id_exception = exc;
    id_bubble    = 1'b0;
    @(negedge clk);                            // Accept edge behind us
    id_bubble    = 1'b1;
    id_exception = '0;
    e = lsu_exception;
    r = '0;
    if (e == '0) begin
      if (!lsu_stall) report_failure("no access started for a clean load or store");
      n = 0;
      while (lsu_bubble) begin
        @(negedge clk);
        n++;
        if (n > 20) report_failure("access did not complete within 20 cycles");
      end
      if (lsu_stall) report_failure("lsu_stall still high at completion");
      r = lsu_r;
      @(negedge clk);
      if (!lsu_bubble) report_failure("lsu_bubble low for more than one cycle");
    end
  endtask

  task automatic do_store(input logic [2:0] f3, input logic [XLEN-1:0] addr, data,
                          input logic [11:0] imm);
    logic [XLEN-1:0]  r;
    logic [EXC_W-1:0] e;
    ref_store(addr[9:0], f3, data);
    run_instr(enc_store(f3, imm), addr - {{20{imm[11]}}, imm}, data, '0, r, e);
    check_exc("lsu_exception", e, '0);
    check_data("lsu_r", r, '0);                // Stores return zero
  endtask

  task automatic do_load(input logic [2:0] f3, input logic [XLEN-1:0] addr, off);
    logic [XLEN-1:0]  r;
    logic [EXC_W-1:0] e;
    run_instr(enc_load(f3), addr - off, off, '0, r, e);
    check_exc("lsu_exception", e, '0);
    check_data("lsu_r", r, ref_load(addr[9:0], f3));
  endtask

  // Refused access, no stall and no completion afterwards
  task automatic expect_refusal(input logic [ILEN-1:0] instr, input logic [XLEN-1:0] a, b,
                                input logic [EXC_W-1:0] exc, exp);
    logic [XLEN-1:0]  r;
    logic [EXC_W-1:0] e;
    run_instr(instr, a, b, exc, r, e);
    check_exc("lsu_exception", e, exp);
    repeat (4) begin
      if (lsu_stall || !lsu_bubble) report_failure("refused access still reached memory");
      @(negedge clk);
    end
  endtask

  //////////////////////////////////////////////////
  // Tests

  task automatic test_word_roundtrip();
    do_store(F3_W, 32'h40, 32'hdeadbeef, 12'h010);
    do_load(F3_W, 32'h40, 32'h8);
  endtask

  task automatic test_lane_merge();
    do_store(F3_W, 32'h80, 32'h11223344, 12'h000);
    do_store(F3_B, 32'h81, 32'h000000a5, 12'hffc);   // Negative offset
    do_store(F3_H, 32'h82, 32'h00008001, 12'h004);
    do_load(F3_B, 32'h81, 32'h0);
    do_load(F3_H, 32'h82, 32'h2);
    do_load(F3_BU, 32'h81, 32'h1);
    do_load(F3_HU, 32'h82, 32'h0);
    do_load(F3_W, 32'h80, 32'h10);
  endtask

  task automatic test_misaligned();
    logic [EXC_W-1:0] lm;
    logic [EXC_W-1:0] sm;
    lm = '0;
    sm = '0;
    lm[EXC_LOAD_MISALIGNED]  = 1'b1;
    sm[EXC_STORE_MISALIGNED] = 1'b1;
    do_store(F3_W, 32'hc0, rand32(), 12'h000);
    expect_refusal(enc_load(F3_H), 32'hc1, 32'h0, '0, lm);
    expect_refusal(enc_store(F3_W, 12'h002), 32'hc0, 32'h55aa55aa, '0, sm);
    do_load(F3_W, 32'hc0, 32'h0);                    // Word untouched
  endtask

  task automatic test_id_exception();
    do_store(F3_W, 32'h100, 32'hcafef00d, 12'h000);
    expect_refusal(enc_store(F3_W, 12'h000), 32'h100, 32'h12345678, 8'h02, 8'h02);
    do_load(F3_W, 32'h100, 32'h0);
  endtask

  task automatic test_no_accept();
    @(negedge clk);
    id_instr  = {12'h005, 5'd1, 3'b000, 5'd2, OPC_OP_IMM, 2'b11};   // ADDI
    id_bubble = 1'b0;
    repeat (3) begin
      @(negedge clk);
      if (!lsu_bubble || lsu_stall) report_failure("non-memory opcode started an access");
    end
    id_instr = enc_load(F3_W);
    op_a     = 32'h40;
    op_b     = 32'h0;
    ex_stall = 1'b1;
    repeat (3) begin
      @(negedge clk);
      if (!lsu_bubble || lsu_stall) report_failure("load accepted while ex_stall was high");
    end
    id_bubble = 1'b1;
    ex_stall  = 1'b0;
    do_load(F3_W, 32'h40, 32'h0);                    // Unit still usable
  endtask

  task automatic test_random();
    logic [31:0]     r;
    logic [2:0]      f3;
    logic [9:0]      addr;
    logic [XLEN-1:0] imm;
    repeat (40) begin
      r = rand32();
      case (r[1:0])
        2'd0:    f3 = F3_B;
        2'd1:    f3 = F3_H;
        default: f3 = F3_W;
      endcase
      addr = {r[9:2], 2'b00};
      if (f3 == F3_B) addr[1:0] = r[11:10];          // Any byte lane
      if (f3 == F3_H) addr[1]   = r[10];             // Halfword boundary
      imm = rand32();
      do_store(f3, {22'b0, addr}, rand32(), imm[11:0]);
      if (r[12] && f3 != F3_W) f3 = (f3 == F3_B) ? F3_BU : F3_HU;
      do_load(f3, {22'b0, addr}, rand32());
    end
  endtask

  //////////////////////////////////////////////////
  // Sequence and watchdog

  initial begin
    #((N_ACC * 20 + RST_CYCLES + 8) * CLK_PERIOD);
    report_failure("watchdog expired before the tests finished");
  end

  initial begin
    wait (i_lsu_top.i_lsu_issue.i_lsu_assert.fail_count != 0);
    report_failure("handshake assertion failed in lsu_issue");
  end

  initial begin
    rstn         = 1'b0;
    ex_stall     = 1'b0;
    id_bubble    = 1'b1;
    id_instr     = '0;
    id_exception = '0;
    op_a         = '0;
    op_b         = '0;
    repeat (RST_CYCLES) @(posedge clk);
    @(negedge clk);
    rstn = 1'b1;
    if (lsu_stall || !lsu_bubble) report_failure("wrong stall or bubble state after reset");
    check_exc("lsu_exception", lsu_exception, '0);
    test_word_roundtrip();
    test_lane_merge();
    test_misaligned();
    test_id_exception();
    test_no_accept();
    test_random();
    repeat (2) @(negedge clk);
    if (i_lsu_top.i_lsu_issue.i_lsu_assert.fail_count == 0) begin
      $display("Result: PASSED");
      $finish;
    end else begin
      report_failure("handshake assertion failed in lsu_issue");
    end
  end

endmodule

`default_nettype wire

// File: sim/lsu_assert.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_assert import lsu_pkg::*; (
  input logic            clk,
  input logic            rstn,
  input logic            req,
  input logic            ack,
  input logic [XLEN-1:0] adr,
  input logic [XLEN-1:0] d,
  input logic            we,
  input size_e           size,
  input logic            lsu_stall
);

  int fail_count = 0;  // Assertion failures so far

  //////////////////////////////////////////////////
  // Four-phase handshake, master side

  a_req_held: assert property (@(posedge clk) disable iff (!rstn)
    req && !ack |=> req)                                  // No early drop
    else begin
      $error("req fell before ack");
      fail_count++;
    end

  a_fields_stable: assert property (@(posedge clk) disable iff (!rstn)
    req |=> (!req || $stable({adr, d, we, size})))
    else begin
      $error("bus fields moved under req");
      fail_count++;
    end

  a_ack_needs_req: assert property (@(posedge clk) disable iff (!rstn)
    $rose(ack) |-> $past(req))
    else begin
      $error("ack rose without req");
      fail_count++;
    end

  // Any request is covered by the unit's stall
  a_req_stall: assert property (@(posedge clk) disable iff (!rstn)
    req |-> lsu_stall)
    else begin
      $error("req high with lsu_stall low");
      fail_count++;
    end

endmodule

bind lsu_issue lsu_assert i_lsu_assert (
  .clk       (clk),
  .rstn      (rstn),
  .req       (mem.req),
  .ack       (mem.ack),
  .adr       (mem.adr),
  .d         (mem.d),
  .we        (mem.we),
  .size      (mem.size),
  .lsu_stall (lsu_stall)
);

`default_nettype wire

// File: src/lsu_top.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_top import lsu_pkg::*; (
  input  logic             clk,
  input  logic             rstn,
  input  logic             ex_stall,
  input  logic             id_bubble,
  input  logic [ILEN-1:0]  id_instr,
  input  logic [EXC_W-1:0] id_exception,
  input  logic [XLEN-1:0]  op_a,
  input  logic [XLEN-1:0]  op_b,
  output logic             lsu_stall,
  output logic             lsu_bubble,
  output logic [XLEN-1:0]  lsu_r,
  output logic [EXC_W-1:0] lsu_exception
);

  logic [2:0] acc_func3;
  logic [1:0] acc_lane;

  // Unit to RAM
  dmem_if bus ();

  lsu_issue i_lsu_issue (
    .clk           (clk),
    .rstn          (rstn),
    .ex_stall      (ex_stall),
    .id_bubble     (id_bubble),
    .id_instr      (id_instr),
    .id_exception  (id_exception),
    .op_a          (op_a),
    .op_b          (op_b),
    .mem           (bus.master),
    .lsu_stall     (lsu_stall),
    .lsu_bubble    (lsu_bubble),
    .lsu_exception (lsu_exception),
    .acc_func3     (acc_func3),
    .acc_lane      (acc_lane)
  );

  dmem_ram i_dmem_ram (
    .clk  (clk),
    .rstn (rstn),
    .mem  (bus.slave)
  );

  // Result path straight off the RAM output register
  load_align i_load_align (
    .q         (bus.q),
    .acc_func3 (acc_func3),
    .acc_lane  (acc_lane),
    .lsu_r     (lsu_r)
  );

endmodule

`default_nettype wire

// File: src/load_align.sv
`timescale 1ns/1ps
`default_nettype none

module load_align import lsu_pkg::*; (
  input  logic [XLEN-1:0] q,
  input  logic [2:0]      acc_func3,
  input  logic [1:0]      acc_lane,
  output logic [XLEN-1:0] lsu_r
);

  logic [XLEN-1:0] sh;    // Addressed byte moved to lane 0

  assign sh = q >> {acc_lane, 3'b000};

  //////////////////////////////////////////////////
  // Extension

  always_comb begin
    case (acc_func3)
      // Signed
      F3_B:  lsu_r = {{(XLEN-8){sh[7]}}, sh[7:0]};
      F3_H:  lsu_r = {{(XLEN-16){sh[15]}}, sh[15:0]};
      F3_W:  lsu_r = sh;                            // Lane is zero here
      // Unsigned
      F3_BU: lsu_r = {{(XLEN-8){1'b0}}, sh[7:0]};
      F3_HU: lsu_r = {{(XLEN-16){1'b0}}, sh[15:0]};
      // Stores and unknown codes
      default: lsu_r = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: src/dmem_ram.sv
`timescale 1ns/1ps
`default_nettype none

module dmem_ram import lsu_pkg::*; (
  input  logic  clk,
  input  logic  rstn,
  dmem_if.slave mem
);

  logic [XLEN-1:0]   ram [RAM_WORDS];
  logic [RAM_AW-1:0] widx;     // Word index
  logic [LANES-1:0]  be;       // Byte enables
  logic              access;   // Phase 1 seen, not yet acked

  // Upper address bits wrap
  assign widx   = mem.adr[RAM_AW+1:2];
  assign access = mem.req && !mem.ack;

  //////////////////////////////////////////////////
  // Lane select

  always_comb begin
    case (mem.size)
      SIZE_BYTE:  be = LANES'(1) << mem.adr[1:0];
      SIZE_HWORD: be = LANES'(3) << mem.adr[1:0];
      SIZE_WORD:  be = '1;
      default:    be = '0;     // Undefined size writes nothing
    endcase
  end

  //////////////////////////////////////////////////
  // Handshake

  // ack follows req by one cycle, both edges
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      mem.ack <= 1'b0;
    end else begin
      mem.ack <= mem.req;
    end
  end

  // Array access once per request
  always_ff @(posedge clk) begin
    if (access) begin
      if (mem.we) begin
        for (int i = 0; i < LANES; i++) begin
          if (be[i]) ram[widx][8*i +: 8] <= mem.d[8*i +: 8];
        end
      end else begin
        mem.q <= ram[widx];    // Valid together with ack
      end
    end
  end

endmodule

`default_nettype wire

// File: src/lsu_issue.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_issue import lsu_pkg::*; (
  input  logic             clk,
  input  logic             rstn,
  input  logic             ex_stall,
  input  logic             id_bubble,
  input  logic [ILEN-1:0]  id_instr,
  input  logic [EXC_W-1:0] id_exception,
  input  logic [XLEN-1:0]  op_a,
  input  logic [XLEN-1:0]  op_b,
  dmem_if.master           mem,
  output logic             lsu_stall,
  output logic             lsu_bubble,
  output logic [EXC_W-1:0] lsu_exception,
  output logic [2:0]       acc_func3,    // Held load code for the aligner
  output logic [1:0]       acc_lane      // Held low address bits
);

  opcode_e          opcode;
  logic [2:0]       func3;
  logic [XLEN-1:0]  imm_s;
  logic             is_load;
  logic             is_store;
  logic             is_mem;
  logic [XLEN-1:0]  adr;
  size_e            size;
  logic [XLEN-1:0]  d;
  logic             misaligned;
  logic [EXC_W-1:0] mis_exc;
  logic             take;    // Instruction presented and unit free
  logic             issue;   // Taken and clean, goes to memory
  issue_state_e     state;

  //////////////////////////////////////////////////
  // Decode

  assign opcode = opcode_e'(id_instr[6:2]);
  assign func3  = id_instr[14:12];

  // S-type immediate
  assign imm_s = {{(XLEN-11){id_instr[31]}}, id_instr[30:25], id_instr[11:7]};

  assign is_load  = (opcode == OPC_LOAD);
  assign is_store = (opcode == OPC_STORE);
  assign is_mem   = is_load | is_store;

  // Effective address
  assign adr = is_store ? op_a + imm_s : op_a + op_b;

  // func3 to access size
  always_comb begin
    case (func3)
      F3_B, F3_BU: size = SIZE_BYTE;
      F3_H, F3_HU: size = SIZE_HWORD;
      F3_W:        size = SIZE_WORD;
      default:     size = SIZE_UNDEF;
    endcase
  end

  // Store data into its byte lanes
  always_comb begin
    case (size)
      SIZE_BYTE:  d = XLEN'(op_b[7:0]) << {adr[1:0], 3'b000};
      SIZE_HWORD: d = XLEN'(op_b[15:0]) << {adr[1:0], 3'b000};
      default:    d = op_b;
    endcase
  end

  // Halfword on odd byte, word off a word boundary
  always_comb begin
    case (size)
      SIZE_HWORD: misaligned = adr[0];
      SIZE_WORD:  misaligned = |adr[1:0];
      default:    misaligned = 1'b0;
    endcase
  end

  always_comb begin
    mis_exc = '0;
    if (is_mem && misaligned) begin
      if (is_store) mis_exc[EXC_STORE_MISALIGNED] = 1'b1;
      else          mis_exc[EXC_LOAD_MISALIGNED]  = 1'b1;
    end
  end

  assign take  = (state == ST_IDLE) && !ex_stall && !id_bubble;
  assign issue = take && is_mem && !misaligned && !(|id_exception);

  //////////////////////////////////////////////////
  // Access machine

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state         <= ST_IDLE;
      mem.req       <= 1'b0;
      lsu_stall     <= 1'b0;
      lsu_bubble    <= 1'b1;
      lsu_exception <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          lsu_bubble <= 1'b1;                  // Nothing completes here
          if (take) begin
            // Incoming exception wins over own checks
            lsu_exception <= (|id_exception) ? id_exception : mis_exc;
          end
          if (issue) begin
            state     <= ST_REQ;
            mem.req   <= 1'b1;
            lsu_stall <= 1'b1;
          end
        end
        ST_REQ: begin
          if (mem.ack) begin
            mem.req <= 1'b0;                   // Phase 3
            state   <= ST_RELEASE;
          end
        end
        ST_RELEASE: begin
          if (!mem.ack) state <= ST_DONE;      // Phase 4 seen
        end
        ST_DONE: begin
          lsu_stall  <= 1'b0;
          lsu_bubble <= 1'b0;                  // One cycle result marker
          state      <= ST_IDLE;
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // Bus fields and aligner info, only loaded while req and ack are low
  always_ff @(posedge clk) begin
    if (issue) begin
      mem.adr   <= adr;
      mem.d     <= d;
      mem.we    <= is_store;
      mem.size  <= size;
      acc_func3 <= is_store ? F3_NONE : func3;  // Stores read back zero
      acc_lane  <= adr[1:0];
    end
  end

endmodule

`default_nettype wire

// File: src/dmem_if.sv
`timescale 1ns/1ps
`default_nettype none

// Data memory bus, four-phase req/ack
interface dmem_if import lsu_pkg::*; ();

  logic [XLEN-1:0] adr;   // Byte address
  logic [XLEN-1:0] d;     // Write data, already lane shifted
  logic            we;
  size_e           size;
  logic            req;
  logic            ack;
  logic [XLEN-1:0] q;     // Read word, valid with ack

  // Load/store unit side
  modport master (
    output adr, d, we, size, req,
    input  ack, q
  );

  // Memory side
  modport slave (
    input  adr, d, we, size, req,
    output ack, q
  );

endinterface

`default_nettype wire

// File: src/lsu_pkg.sv
`default_nettype none

package lsu_pkg;

  //////////////////////////////////////////////////
  // Widths
  localparam int XLEN      = 32;          // Data and address
  localparam int ILEN      = 32;          // Instruction word
  localparam int EXC_W     = 8;           // Exception vector
  localparam int LANES     = XLEN / 8;    // Byte lanes per word
  localparam int RAM_WORDS = 256;
  localparam int RAM_AW    = $clog2(RAM_WORDS);

  // Exception bit positions
  localparam int EXC_LOAD_MISALIGNED  = 4;
  localparam int EXC_STORE_MISALIGNED = 6;

  //////////////////////////////////////////////////
  // Major opcodes, instr[6:2]
  typedef enum logic [4:0] {
    OPC_LOAD     = 5'b00000,
    OPC_MISC_MEM = 5'b00011,
    OPC_OP_IMM   = 5'b00100,
    OPC_AUIPC    = 5'b00101,
    OPC_STORE    = 5'b01000,
    OPC_OP       = 5'b01100,
    OPC_LUI      = 5'b01101,
    OPC_BRANCH   = 5'b11000,
    OPC_JALR     = 5'b11001,
    OPC_JAL      = 5'b11011,
    OPC_SYSTEM   = 5'b11100
  } opcode_e;

  // func3 of loads and stores
  localparam logic [2:0] F3_B    = 3'b000;
  localparam logic [2:0] F3_H    = 3'b001;
  localparam logic [2:0] F3_W    = 3'b010;
  localparam logic [2:0] F3_BU   = 3'b100;
  localparam logic [2:0] F3_HU   = 3'b101;
  localparam logic [2:0] F3_NONE = 3'b111;  // Store in flight, no load result

  // Access size on the bus
  typedef enum logic [2:0] {
    SIZE_BYTE  = 3'b000,
    SIZE_HWORD = 3'b001,
    SIZE_WORD  = 3'b010,
    SIZE_UNDEF = 3'b111
  } size_e;

  // Access machine
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_REQ,      // req high, waiting on ack
    ST_RELEASE,  // req low, waiting for ack to drop
    ST_DONE
  } issue_state_e;

endpackage

`default_nettype wire
